//--- verilog/prach_pkg.sv
package prach_pkg;

  // --------------------
  // sizes.
  localparam int NUM_CC      = 2;
  localparam int NUM_ANT     = 2;
  localparam int NUM_CH      = NUM_CC * NUM_ANT;
  localparam int SYMBOL_LEN  = 16;
  localparam int MAX_SYMBOLS = 4;
  localparam int BUF_DEPTH   = MAX_SYMBOLS * SYMBOL_LEN;
  localparam int OUT_CREDITS = 8;

  // --------------------
  // vector types.
  typedef logic [15:0] iq_t;
  typedef logic [7:0]  chn_t;
  typedef logic [15:0] sample_k_t;
  typedef logic [31:0] hdr_t;
  typedef logic [5:0]  addr_t;
  typedef logic [2:0]  nsym_t;
  typedef logic [6:0]  len_t;
  typedef logic [3:0]  credit_t;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ARMED,
    CAP_FILL,
    CAP_READY
  } cap_state_t;

  // --------------------
  // bundles.
  typedef struct packed {
    iq_t  dr;
    iq_t  di;
    chn_t chn;
  } sample_t;

  typedef struct packed {
    hdr_t      header;
    sample_k_t time_offset;
    nsym_t     num_symbol;
  } cplane_req_t;

  // window offered to the readout.
  typedef struct packed {
    hdr_t hdr;
    len_t len;
  } window_t;

endpackage

//--- verilog/prach_capture.sv
`timescale 1ns/1ns

module prach_capture #(
  parameter int CHANNEL = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  prach_pkg::sample_t    din,
  input  prach_pkg::sample_k_t  sample_k,
  input  logic                  c_valid,
  input  prach_pkg::cplane_req_t c_req,
  input  prach_pkg::addr_t      rd_addr,
  input  logic                  rd_en,
  input  logic                  ap_ack,
  output logic                  ap_req,
  output prach_pkg::window_t    ap_win,
  output prach_pkg::iq_t [1:0]  rd_data
);

  import prach_pkg::*;

  cap_state_t state;

  // latched request.
  hdr_t       req_hdr;
  sample_k_t  req_offset;
  len_t       req_len;

  len_t       wr_cnt;
  len_t       wr_next;
  addr_t      wr_addr;
  logic       own_chn;
  logic       start_hit;
  logic       wr_en;
  logic       take_req;

  iq_t [1:0]  mem [BUF_DEPTH];

  // --------------------
  // start detection and write enable.
  assign own_chn   = (din.chn == chn_t'(CHANNEL));
  assign start_hit = own_chn && (sample_k == req_offset);
  assign take_req  = (state == CAP_IDLE) && c_valid;

  always_comb begin
    wr_en = 1'b0;
    if (state == CAP_FILL) begin
      wr_en = own_chn;
    end else if (state == CAP_ARMED) begin
      wr_en = start_hit;
    end
  end

  assign wr_next = wr_cnt + 1'b1;
  assign wr_addr = addr_t'(wr_cnt);

  // --------------------
  // FSM.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= CAP_IDLE;
      wr_cnt <= '0;
    end else begin
      case (state)
        CAP_IDLE: begin
          wr_cnt <= '0;
          if (c_valid) begin
            state <= CAP_ARMED;
          end
        end
        CAP_ARMED, CAP_FILL: begin
          if (wr_en) begin
            wr_cnt <= wr_next;
            if (wr_next == req_len) begin
              state <= CAP_READY;
            end else begin
              state <= CAP_FILL;
            end
          end
        end
        CAP_READY: begin
          // readout has taken the whole window.
          if (ap_ack) begin
            state <= CAP_IDLE;
          end
        end
        default: begin
          state <= CAP_IDLE;
        end
      endcase
    end
  end

  // requests outside idle are dropped.
  always_ff @(posedge clk) begin
    if (take_req) begin
      req_hdr    <= c_req.header;
      req_offset <= c_req.time_offset;
      req_len    <= len_t'(c_req.num_symbol) * len_t'(SYMBOL_LEN);
    end
  end

  // --------------------
  // sample RAM.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= {din.dr, din.di};
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  assign ap_req     = (state == CAP_READY);
  assign ap_win.hdr = req_hdr;
  assign ap_win.len = wr_cnt;

endmodule

//--- verilog/prach_readout.sv
`timescale 1ns/1ns

module prach_readout (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [prach_pkg::NUM_CH-1:0]  ap_req,
  input  prach_pkg::window_t            ap_win [prach_pkg::NUM_CH],
  input  prach_pkg::iq_t [1:0]          rd_data [prach_pkg::NUM_CH],
  input  logic                          credit_return,
  output logic [prach_pkg::NUM_CH-1:0]  ap_ack,
  output prach_pkg::addr_t              rd_addr,
  output logic [prach_pkg::NUM_CH-1:0]  rd_en,
  output prach_pkg::iq_t [1:0]          dout,
  output logic                          dout_dv,
  output logic                          sync_out,
  output prach_pkg::hdr_t               hdr_out
);

  import prach_pkg::*;

  logic                      busy;
  logic [$clog2(NUM_CH)-1:0] last_sel;
  logic [$clog2(NUM_CH)-1:0] grant;
  logic                      grant_vld;
  window_t                   win;
  len_t                      rd_cnt;
  credit_t                   credit;
  logic                      first_q;
  logic                      last_q;
  logic                      issue;
  logic                      drain;
  logic                      rd_last;

  // --------------------
  // round robin starting after the last served buffer.
  always_comb begin
    logic [$clog2(NUM_CH)-1:0] cand;
    cand      = last_sel;
    grant     = last_sel;
    grant_vld = 1'b0;
    for (int i = 0; i < NUM_CH; i++) begin
      cand = cand + 1'b1;
      if (!grant_vld && ap_req[cand]) begin
        grant_vld = 1'b1;
        grant     = cand;
      end
    end
  end

  assign issue   = busy && (credit != '0);
  assign rd_last = (rd_cnt == win.len - 1'b1);
  // served buffer still shows ap_req until its ack lands.
  assign drain   = ((|rd_en) && last_q) || (|ap_ack);

  // --------------------
  // control.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      last_sel <= ($clog2(NUM_CH))'(NUM_CH - 1);
      rd_cnt   <= '0;
      rd_en    <= '0;
      first_q  <= 1'b0;
      last_q   <= 1'b0;
      ap_ack   <= '0;
      dout_dv  <= 1'b0;
      sync_out <= 1'b0;
      credit   <= credit_t'(OUT_CREDITS);
    end else begin
      rd_en    <= '0;
      ap_ack   <= last_q ? rd_en : '0;
      dout_dv  <= |rd_en;
      sync_out <= (|rd_en) && first_q;
      credit   <= credit - credit_t'(issue) + credit_t'(credit_return);
      if (!busy && !drain && grant_vld) begin
        busy     <= 1'b1;
        last_sel <= grant;
        rd_cnt   <= '0;
      end else if (issue) begin
        rd_en[last_sel] <= 1'b1;
        rd_cnt          <= rd_cnt + 1'b1;
        first_q         <= (rd_cnt == '0);
        last_q          <= rd_last;
        if (rd_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // window and output payload.
  always_ff @(posedge clk) begin
    if (!busy && !drain && grant_vld) begin
      win <= ap_win[grant];
    end
    if (issue) begin
      rd_addr <= addr_t'(rd_cnt);
    end
    if ((|rd_en) && first_q) begin
      hdr_out <= win.hdr;
    end
  end

  // last_sel holds until the last word has left.
  assign dout = rd_data[last_sel];

endmodule

//--- verilog/prach_buffer.sv
`timescale 1ns/1ns

module prach_buffer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  prach_pkg::sample_t            din,
  input  logic                          sync_in,
  input  logic [prach_pkg::NUM_CH-1:0]  c_valid,
  input  prach_pkg::cplane_req_t        c_req,
  input  logic                          credit_return,
  output prach_pkg::iq_t [1:0]          dout,
  output logic                          dout_dv,
  output logic                          sync_out,
  output prach_pkg::hdr_t               hdr_out
);

  import prach_pkg::*;

  sample_t           din_q;
  sample_k_t         sample_k;

  logic [NUM_CH-1:0] ap_req;
  logic [NUM_CH-1:0] ap_ack;
  logic [NUM_CH-1:0] rd_en;
  window_t           ap_win  [NUM_CH];
  iq_t [1:0]         rd_data [NUM_CH];
  addr_t             rd_addr;

  // --------------------
  // input register and frame sample counter.
  always_ff @(posedge clk) begin
    din_q <= din;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_k <= '0;
    end else if (sync_in) begin
      sample_k <= '0;
    end else if (din.chn == '0) begin
      sample_k <= sample_k + 1'b1;
    end
  end

  // --------------------
  // one buffer per carrier and antenna at channel cc * 16 + ant.
  for (genvar cc = 0; cc < NUM_CC; cc++) begin : g_cc
    for (genvar ant = 0; ant < NUM_ANT; ant++) begin : g_ant
      prach_capture #(
        .CHANNEL(cc * 16 + ant)
      ) u_capture (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din_q),
        .sample_k (sample_k),
        .c_valid  (c_valid[cc * NUM_ANT + ant]),
        .c_req    (c_req),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en[cc * NUM_ANT + ant]),
        .ap_ack   (ap_ack[cc * NUM_ANT + ant]),
        .ap_req   (ap_req[cc * NUM_ANT + ant]),
        .ap_win   (ap_win[cc * NUM_ANT + ant]),
        .rd_data  (rd_data[cc * NUM_ANT + ant])
      );
    end
  end

  prach_readout u_readout (
    .clk           (clk),
    .rst_n         (rst_n),
    .ap_req        (ap_req),
    .ap_win        (ap_win),
    .rd_data       (rd_data),
    .credit_return (credit_return),
    .ap_ack        (ap_ack),
    .rd_addr       (rd_addr),
    .rd_en         (rd_en),
    .dout          (dout),
    .dout_dv       (dout_dv),
    .sync_out      (sync_out),
    .hdr_out       (hdr_out)
  );

endmodule

//--- bench/prach_buffer_tb.sv
`timescale 1ns/1ns

module prach_buffer_tb;

  import prach_pkg::*;

  // rough cycle budget per test, summed.
  localparam int TEST_CYCLES = 20 + 320 + 190 + 250 + 330 + 120;

  typedef struct packed {
    iq_t  dr;
    iq_t  di;
    logic sync;
    hdr_t hdr;
  } beat_t;

  logic              clk = 1'b0;
  logic              rst_n;
  sample_t           din;
  logic              sync_in;
  logic [NUM_CH-1:0] c_valid;
  cplane_req_t       c_req;
  logic              credit_return;
  iq_t [1:0]         dout;
  logic              dout_dv;
  logic              sync_out;
  hdr_t              hdr_out;

  int          errors = 0;
  int          frame_k = 0;
  int          pos = 0;
  int          cycle = 0;
  int          beats = 0;
  int          returned = 0;
  int          credit_delay = 2;
  logic        stream_on = 1'b0;
  logic        sync_req = 1'b0;
  logic        stall = 1'b0;
  logic [31:0] lfsr = 32'h1353;
  iq_t         di_hist [int];
  beat_t       rx_q [$];
  int          credit_due [$];

  always #4 clk = ~clk;

  prach_buffer i_prach_buffer (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s >> 1;
    if (s[0]) begin
      lfsr_next = lfsr_next ^ 32'h8020_0003;
    end
  endfunction

  // --------------------
  // stream of channels 0, 1, 16, 17 in turn.
  always @(negedge clk) begin : drive
    iq_t di_bits;
    if (stream_on) begin
      if (pos == 0) begin
        frame_k = frame_k + 1;
      end
      for (int b = 0; b < 16; b++) begin
        di_bits[b] = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
      din = '{dr: iq_t'(frame_k), di: di_bits,
              chn: chn_t'((pos / NUM_ANT) * 16 + pos % NUM_ANT)};
      di_hist[pos * 65536 + frame_k] = di_bits;
      sync_in = 1'b0;
      // new frame starts right after the last channel of a group.
      if (pos == NUM_CH - 1 && sync_req) begin
        sync_in = 1'b1;
        frame_k = 0;
        sync_req = 1'b0;
      end
      pos = (pos + 1) % NUM_CH;
    end
  end

  // --------------------
  // output monitor and credit return.
  always @(negedge clk) begin : monitor
    beat_t b;
    cycle = cycle + 1;
    if (dout_dv) begin
      b.dr = dout[1];
      b.di = dout[0];
      b.sync = sync_out;
      b.hdr = hdr_out;
      rx_q.push_back(b);
      credit_due.push_back(cycle + credit_delay);
      beats = beats + 1;
    end
    assert (beats <= returned + OUT_CREDITS) else begin
      errors++;
      $display("credit overrun, %0d beats sent with only %0d credits returned", beats, returned);
    end
    credit_return = 1'b0;
    if (!stall && credit_due.size() > 0 && credit_due[0] <= cycle) begin
      void'(credit_due.pop_front());
      credit_return = 1'b1;
      returned = returned + 1;
    end
  end

  task automatic check_value(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp == act) else begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic send_request(input int p, input hdr_t hdr, input int t, input int nsym);
    @(negedge clk);
    c_valid = '0;
    c_valid[p] = 1'b1;
    c_req = '{header: hdr, time_offset: sample_k_t'(t), num_symbol: nsym_t'(nsym)};
    @(negedge clk);
    c_valid = '0;
  endtask

  task automatic wait_beats(input int n);
    while (rx_q.size() < n) begin
      @(negedge clk);
    end
  endtask

  task automatic check_window(input string name, input int base, input int p, input hdr_t hdr,
                              input int t, input int len);
    beat_t b;
    for (int i = 0; i < len; i++) begin
      b = rx_q[base + i];
      check_value(name, "dr", t + i, b.dr);
      check_value(name, "di", di_hist[p * 65536 + t + i], b.di);
      check_value(name, "sync_out", i == 0, b.sync);
      if (i == 0) begin
        check_value(name, "hdr_out", hdr, b.hdr);
      end
    end
  endtask

  // --------------------
  // directed tests.
  task automatic reset_state();
    repeat (20) begin
      @(negedge clk);
      check_value("reset_state", "dout_dv", 0, dout_dv);
      check_value("reset_state", "sync_out", 0, sync_out);
    end
  endtask

  task automatic round_robin();
    int t;
    t = frame_k + 6;
    for (int p = 0; p < NUM_CH; p++) begin
      send_request(p, 32'hA000_0000 + p, t, 2);
    end
    wait_beats(NUM_CH * 32);
    for (int p = 0; p < NUM_CH; p++) begin
      check_window("round_robin", p * 32, p, 32'hA000_0000 + p, t, 32);
    end
    rx_q.delete();
  endtask

  task automatic single_capture();
    int t;
    t = frame_k + 4;
    send_request(2, 32'h1600_00C5, t, 2);
    wait_beats(32);
    check_window("single_capture", 0, 2, 32'h1600_00C5, t, 32);
    rx_q.delete();
  endtask

  task automatic back_pressure();
    int t;
    while (credit_due.size() != 0) begin
      @(negedge clk);
    end
    stall = 1'b1;
    t = frame_k + 4;
    send_request(3, 32'hB0B0_0017, t, 2);
    wait_beats(OUT_CREDITS);
    repeat (40) @(negedge clk);
    check_value("back_pressure", "beats while stalled", OUT_CREDITS, rx_q.size());
    stall = 1'b0;
    wait_beats(32);
    check_window("back_pressure", 0, 3, 32'hB0B0_0017, t, 32);
    rx_q.delete();
  endtask

  task automatic busy_drop();
    int t;
    t = frame_k + 8;
    send_request(1, 32'hC001_0001, t, 1);
    // buffer is armed now, so this one is lost.
    send_request(1, 32'hC001_0002, t + 2, 1);
    wait_beats(16);
    repeat (200) @(negedge clk);
    check_value("busy_drop", "beat count", 16, rx_q.size());
    check_window("busy_drop", 0, 1, 32'hC001_0001, t, 16);
    rx_q.delete();
  endtask

  task automatic frame_sync();
    int t;
    sync_req = 1'b1;
    while (sync_req) begin
      @(negedge clk);
    end
    t = frame_k + 4;
    send_request(0, 32'h5A5A_0000, t, 1);
    wait_beats(16);
    check_window("frame_sync", 0, 0, 32'h5A5A_0000, t, 16);
    rx_q.delete();
  endtask

  // --------------------
  initial begin
    rst_n = 1'b0;
    din = '{dr: '0, di: '0, chn: 8'hFF};
    sync_in = 1'b0;
    c_valid = '0;
    c_req = '0;
    credit_return = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    stream_on = 1'b1;
    reset_state();
    round_robin();
    single_capture();
    back_pressure();
    busy_drop();
    frame_sync();
    $display("tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(2 * TEST_CYCLES * 8 + 1000);
    $display("timeout, the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

//--- build.f
verilog/prach_pkg.sv
verilog/prach_capture.sv
verilog/prach_readout.sv
verilog/prach_buffer.sv
bench/prach_buffer_tb.sv

//--- run.sh
#!/bin/sh
# build and run the PRACH buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module prach_buffer_tb -o prach_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/prach_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0
